/* logic/cpuPkg.sv */
`default_nettype none

package cpuPkg;

  localparam int dataWidth    = 32;
  localparam int regAddrWidth = 5;
  localparam int memDepth     = 256;
  localparam int memAddrWidth = 8;   // Word index, byte address bits 9:2

  // Opcode map, opc bit 3 set selects the immediate for operand B
  //   add     00x000  rd = ra + B
  //   logic   10x0oo  op in bits 1:0, 00 or, 01 and, 10 xor, 11 and-not
  //   shift   100100  rd = ra >> 1, logical
  //   barrel  01x001  rd = ra shifted by B[4:0], left when alt bit 10 is set
  //   load    11x010  rd = mem[ra + B]
  //   store   11x110  mem[ra + imm] = rd
  // Stores always take the immediate offset. Read port B carries rd for them.
  // Any other opcode runs as a no-op and writes nothing.

  // Immediate is {rb, alt}, sign-extended to dataWidth
  typedef struct packed {
    logic [5:0]              opc;
    logic [regAddrWidth-1:0] rd;
    logic [regAddrWidth-1:0] ra;
    logic [regAddrWidth-1:0] rb;
    logic [10:0]             alt;
  } instT;

  // Operand source for X
  typedef enum logic [1:0] {
    selReg,   // Register file value read in D
    selFwd,   // Result of the instruction that was in X
    selMem,   // Value written back while in D, load data included
    selImm
  } srcSelT;

  typedef enum logic [2:0] {
    aluAdd,
    aluLogic,
    aluShift,
    aluBarrel
  } aluSelT;

  typedef struct packed {
    logic                    valid;
    aluSelT                  aluSel;
    logic [1:0]              logicOp;
    logic                    isLoad;
    logic                    isStore;
    logic                    isBarrel;
    logic                    barrelLeft;
    srcSelT                  srcA;
    srcSelT                  srcB;
    logic [regAddrWidth-1:0] rd;
  } xCtrlT;

  // One entry per register write, in program order
  typedef struct packed {
    logic                    valid;
    logic [regAddrWidth-1:0] rd;
    logic [dataWidth-1:0]    data;
  } wbT;

endpackage

`default_nettype wire

/* logic/pipeCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeCtrl (
  input  logic                            gclk,
  input  logic                            arstN,
  input  logic                            instValid,
  input  cpuPkg::instT                    inst,
  output logic                            instReady,
  output logic [cpuPkg::regAddrWidth-1:0] rdA,
  output logic [cpuPkg::regAddrWidth-1:0] rdB,
  output logic [cpuPkg::regAddrWidth-1:0] xDest,
  output logic                            xDestValid,
  output logic [cpuPkg::regAddrWidth-1:0] rDest,
  output logic                            rDestValid,
  output cpuPkg::xCtrlT                   xCtrl,
  output logic [cpuPkg::dataWidth-1:0]    immOut,
  input  logic                            barrelBusy
);
  import cpuPkg::*;

  logic  accept;
  logic  isAdd;
  logic  isLogic;
  logic  isShift;
  logic  isBarrel;
  logic  isLoad;
  logic  isStore;
  logic  known;
  logic  useImm;
  xCtrlT dCtrl;

  // X result wins over R, r0 never matches since both dest flags exclude it
  function automatic srcSelT pickSrc(input logic [regAddrWidth-1:0] r);
    if (xDestValid && (r == xDest))
      return selFwd;
    else if (rDestValid && (r == rDest))
      return selMem;
    else
      return selReg;
  endfunction

  assign instReady = !barrelBusy;   // Only stall is the first barrel cycle
  assign accept    = instValid && instReady;

  // Opcode classes
  assign isAdd    = ({inst.opc[5:4], inst.opc[2:0]} == 5'b00000);
  assign isLogic  = (inst.opc[5:4] == 2'b10) && !inst.opc[2];
  assign isShift  = (inst.opc == 6'b100100);
  assign isBarrel = ({inst.opc[5:4], inst.opc[2:0]} == 5'b01001);
  assign isLoad   = (inst.opc[5:4] == 2'b11) && (inst.opc[2:0] == 3'b010);
  assign isStore  = (inst.opc[5:4] == 2'b11) && (inst.opc[2:0] == 3'b110);
  assign known    = isAdd || isLogic || isShift || isBarrel || isLoad || isStore;
  assign useImm   = inst.opc[3] && !isStore;

  assign rdA = inst.ra;
  assign rdB = isStore ? inst.rd : inst.rb;   // Store data on port B

  always_comb begin
    dCtrl         = '0;
    dCtrl.valid   = accept && known;   // No-ops go down as bubbles
    dCtrl.logicOp = inst.opc[1:0];
    if (isLogic)
      dCtrl.aluSel = aluLogic;
    else if (isShift)
      dCtrl.aluSel = aluShift;
    else if (isBarrel)
      dCtrl.aluSel = aluBarrel;
    else
      dCtrl.aluSel = aluAdd;
    dCtrl.isLoad     = isLoad;
    dCtrl.isStore    = isStore;
    dCtrl.isBarrel   = isBarrel;
    dCtrl.barrelLeft = inst.alt[10];
    dCtrl.srcA       = pickSrc(rdA);
    if (useImm)
      dCtrl.srcB = selImm;
    else
      dCtrl.srcB = pickSrc(rdB);
    dCtrl.rd = inst.rd;
  end

  assign xDest = xCtrl.rd;

  always_ff @(posedge gclk or negedge arstN) begin
    if (!arstN) begin
      xCtrl      <= '0;
      xDestValid <= 1'b0;
      rDest      <= '0;
      rDestValid <= 1'b0;
    end else begin
      // R sees a bubble behind the first barrel cycle
      rDest      <= xDest;
      rDestValid <= xDestValid && !barrelBusy;
      if (!barrelBusy) begin
        xCtrl      <= dCtrl;
        xDestValid <= dCtrl.valid && !isStore && (inst.rd != '0);
      end
    end
  end

  always_ff @(posedge gclk) begin
    if (!barrelBusy)
      immOut <= {{(dataWidth - 16){inst.rb[regAddrWidth-1]}}, inst.rb, inst.alt};
  end

  // Each barrel costs one slot on the port, never two in a row
  aReadyGap: assert property (@(posedge gclk) disable iff (!arstN)
    !instReady |=> instReady)
    else $error("instReady held low for two cycles");

  aLoadStore: assert property (@(posedge gclk) disable iff (!arstN)
    xCtrl.valid |-> !(xCtrl.isLoad && xCtrl.isStore))
    else $error("X holds a load and a store at once");

endmodule

`default_nettype wire

/* logic/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
  input  logic                            gclk,
  input  logic                            arstN,
  input  logic [cpuPkg::regAddrWidth-1:0] rdA,
  input  logic [cpuPkg::regAddrWidth-1:0] rdB,
  output logic [cpuPkg::dataWidth-1:0]    dataA,
  output logic [cpuPkg::dataWidth-1:0]    dataB,
  input  logic                            we,
  input  logic [cpuPkg::regAddrWidth-1:0] wAddr,
  input  logic [cpuPkg::dataWidth-1:0]    wData
);
  import cpuPkg::*;

  logic [dataWidth-1:0] regs [2**regAddrWidth];

  always_ff @(posedge gclk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < 2**regAddrWidth; i++)
        regs[i] <= '0;
    end else if (we && (wAddr != '0)) begin
      regs[wAddr] <= wData;
    end
  end

  // r0 is wired to zero
  assign dataA = (rdA == '0) ? '0 : regs[rdA];
  assign dataB = (rdB == '0) ? '0 : regs[rdB];

  // The write enable already excludes r0 upstream
  aNoZeroWrite: assert property (@(posedge gclk) disable iff (!arstN)
    !(we && (wAddr == '0)))
    else $error("write to r0 reached the register file");

endmodule

`default_nettype wire

/* logic/execUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module execUnit (
  input  logic                            gclk,
  input  logic                            arstN,
  input  cpuPkg::xCtrlT                   xCtrl,
  input  logic [cpuPkg::dataWidth-1:0]    opA,
  input  logic [cpuPkg::dataWidth-1:0]    opB,
  input  logic [cpuPkg::dataWidth-1:0]    imm,
  input  logic [cpuPkg::dataWidth-1:0]    memRdata,
  output logic [cpuPkg::memAddrWidth-1:0] memAddr,
  output logic [cpuPkg::dataWidth-1:0]    memWdata,
  output logic                            memWe,
  output logic                            barrelBusy,
  output cpuPkg::wbT                      wb
);
  import cpuPkg::*;

  logic [dataWidth-1:0]    xOpA;     // Register values read in D
  logic [dataWidth-1:0]    xOpB;
  logic [dataWidth-1:0]    lastWb;   // Last value on the write port
  logic [dataWidth-1:0]    fwdVal;
  logic [dataWidth-1:0]    aVal;
  logic [dataWidth-1:0]    bVal;
  logic [dataWidth-1:0]    addB;
  logic [dataWidth-1:0]    sum;
  logic [dataWidth-1:0]    logicVal;
  logic [dataWidth-1:0]    coarse;
  logic [dataWidth-1:0]    bsCoarse;
  logic [2:0]              bsFine;
  logic [dataWidth-1:0]    barrelOut;
  logic [dataWidth-1:0]    result;
  logic                    barrelPhase;
  logic                    rValid;
  logic                    rIsLoad;
  logic [regAddrWidth-1:0] rRd;
  logic [dataWidth-1:0]    rResult;

  function automatic logic [dataWidth-1:0] pickOperand(input srcSelT sel,
                                                       input logic [dataWidth-1:0] regVal);
    case (sel)
      selFwd:  return fwdVal;
      selMem:  return lastWb;
      selImm:  return imm;
      default: return regVal;
    endcase
  endfunction

  assign fwdVal = rIsLoad ? memRdata : rResult;   // Load data resolves in R

  always_comb begin
    aVal = pickOperand(xCtrl.srcA, xOpA);
    bVal = pickOperand(xCtrl.srcB, xOpB);
  end

  // Shared adder for add and address generation
  assign addB = xCtrl.isStore ? imm : bVal;
  assign sum  = aVal + addB;

  assign memAddr  = sum[memAddrWidth+1:2];
  assign memWdata = bVal;
  assign memWe    = xCtrl.valid && xCtrl.isStore;

  always_comb begin
    case (xCtrl.logicOp)
      2'b00:   logicVal = aVal | bVal;
      2'b01:   logicVal = aVal & bVal;
      2'b10:   logicVal = aVal ^ bVal;
      default: logicVal = aVal & ~bVal;
    endcase
  end

  // Barrel in two steps, byte-granular shift first, then the last 0 to 7 bits
  assign barrelBusy = xCtrl.valid && xCtrl.isBarrel && !barrelPhase;
  assign coarse     = xCtrl.barrelLeft ? (aVal << {bVal[4:3], 3'b000})
                                       : (aVal >> {bVal[4:3], 3'b000});
  assign barrelOut  = xCtrl.barrelLeft ? (bsCoarse << bsFine) : (bsCoarse >> bsFine);

  always_comb begin
    case (xCtrl.aluSel)
      aluLogic:  result = logicVal;
      aluShift:  result = {1'b0, aVal[dataWidth-1:1]};
      aluBarrel: result = barrelOut;
      default:   result = sum;
    endcase
  end

  always_ff @(posedge gclk or negedge arstN) begin
    if (!arstN) begin
      barrelPhase <= 1'b0;
      rValid      <= 1'b0;
      rIsLoad     <= 1'b0;
      rRd         <= '0;
    end else begin
      barrelPhase <= barrelBusy;
      rValid      <= xCtrl.valid && !xCtrl.isStore && (xCtrl.rd != '0) && !barrelBusy;
      rIsLoad     <= xCtrl.isLoad;
      rRd         <= xCtrl.rd;
    end
  end

  always_ff @(posedge gclk) begin
    if (!barrelBusy) begin
      xOpA <= opA;
      xOpB <= opB;
    end else begin
      bsCoarse <= coarse;
      bsFine   <= bVal[2:0];
    end
    rResult <= result;
    lastWb  <= fwdVal;
  end

  assign wb.valid = rValid;
  assign wb.rd    = rRd;
  assign wb.data  = fwdVal;

  // Second barrel cycle always finishes
  aBarrelOnce: assert property (@(posedge gclk) disable iff (!arstN)
    barrelBusy |=> !barrelBusy)
    else $error("barrelBusy high for two cycles");

endmodule

`default_nettype wire

/* logic/dataMem.sv */
`timescale 1ns/1ps
`default_nettype none

module dataMem (
  input  logic                            gclk,
  input  logic [cpuPkg::memAddrWidth-1:0] addr,
  input  logic [cpuPkg::dataWidth-1:0]    wdata,
  input  logic                            we,
  output logic [cpuPkg::dataWidth-1:0]    rdata
);
  import cpuPkg::*;

  logic [dataWidth-1:0] mem [memDepth];

  // Address comes from X, read data lands in R
  always_ff @(posedge gclk) begin
    if (we)
      mem[addr] <= wdata;
    rdata <= mem[addr];   // Old word when reading the word being written
  end

endmodule

`default_nettype wire

/* logic/cpuCore.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuCore (
  input  logic         gclk,
  input  logic         arstN,
  input  logic         instValid,
  input  cpuPkg::instT inst,
  output logic         instReady,
  output cpuPkg::wbT   wb
);
  import cpuPkg::*;

  logic [regAddrWidth-1:0] rdA;
  logic [regAddrWidth-1:0] rdB;
  logic [dataWidth-1:0]    dataA;
  logic [dataWidth-1:0]    dataB;
  logic [regAddrWidth-1:0] rDest;
  logic                    rDestValid;
  xCtrlT                   xCtrl;
  logic [dataWidth-1:0]    immOut;
  logic                    barrelBusy;
  logic [memAddrWidth-1:0] memAddr;
  logic [dataWidth-1:0]    memWdata;
  logic                    memWe;
  logic [dataWidth-1:0]    memRdata;

  pipeCtrl u_pipeCtrl (
    .gclk       (gclk),
    .arstN      (arstN),
    .instValid  (instValid),
    .inst       (inst),
    .instReady  (instReady),
    .rdA        (rdA),
    .rdB        (rdB),
    .xDest      (),
    .xDestValid (),
    .rDest      (rDest),
    .rDestValid (rDestValid),
    .xCtrl      (xCtrl),
    .immOut     (immOut),
    .barrelBusy (barrelBusy)
  );

  // Write port driven from R
  regFile u_regFile (
    .gclk  (gclk),
    .arstN (arstN),
    .rdA   (rdA),
    .rdB   (rdB),
    .dataA (dataA),
    .dataB (dataB),
    .we    (rDestValid),
    .wAddr (rDest),
    .wData (wb.data)
  );

  execUnit u_execUnit (
    .gclk       (gclk),
    .arstN      (arstN),
    .xCtrl      (xCtrl),
    .opA        (dataA),
    .opB        (dataB),
    .imm        (immOut),
    .memRdata   (memRdata),
    .memAddr    (memAddr),
    .memWdata   (memWdata),
    .memWe      (memWe),
    .barrelBusy (barrelBusy),
    .wb         (wb)
  );

  dataMem u_dataMem (
    .gclk  (gclk),
    .addr  (memAddr),
    .wdata (memWdata),
    .we    (memWe),
    .rdata (memRdata)
  );

endmodule

`default_nettype wire

/* verif/tbProgram.sv */
`timescale 1ns/1ps
`default_nettype none

module tbProgram (
  input  logic         gclk,
  input  logic         arstN,
  input  logic         instReady,
  output logic         instValid,
  output cpuPkg::instT inst,
  output logic         done
);
  import cpuPkg::*;

  // Low half is {rb, alt}, the immediate for the immediate forms
  function automatic instT packInst(input logic [5:0] opc, input logic [4:0] rd,
                                    input logic [4:0] ra, input logic [15:0] low);
    return {opc, rd, ra, low};
  endfunction

  // Holds the instruction until the edge that accepts it
  task automatic sendInst(input instT i);
    instValid <= 1'b1;
    inst      <= i;
    @(posedge gclk);
    while (!instReady)
      @(posedge gclk);
  endtask

  task automatic idleCycles(input int n);
    instValid <= 1'b0;
    repeat (n) @(posedge gclk);
  endtask

  function automatic logic [5:0] pickOpcode();
    logic immB;
    immB = 1'($urandom());
    case ($urandom_range(0, 8))
      0, 1:    return {2'b00, immB, 3'b000};               // add
      2, 3:    return {2'b10, immB, 1'b0, 2'($urandom())};  // logic
      4:       return 6'b100100;                            // shift right by one
      5:       return {2'b01, immB, 3'b001};                // barrel
      6:       return {2'b11, immB, 3'b010};                // load
      7:       return {2'b11, immB, 3'b110};                // store
      default: return {2'b11, immB, 3'b111};                // unused, no-op
    endcase
  endfunction

  // Registers kept to r0..r7 so that dependencies are frequent
  function automatic instT randomInst();
    logic [4:0] rb;
    if ($urandom_range(0, 3) == 0)
      rb = 5'($urandom());
    else
      rb = 5'($urandom_range(0, 7));
    return packInst(pickOpcode(), 5'($urandom_range(0, 7)), 5'($urandom_range(0, 7)),
                    {rb, 11'($urandom())});
  endfunction

  initial begin
    void'($urandom(32'h14f3_0b0e));
    instValid = 1'b0;
    inst      = '0;
    done      = 1'b0;
    wait (arstN);
    @(posedge gclk);
    idleCycles(3);

    // Dependent chain through X and R forwarding
    sendInst(packInst(6'b001000, 5'd1, 5'd0, 16'h1234));
    sendInst(packInst(6'b001000, 5'd2, 5'd1, 16'hfffd));         // r1 - 3
    sendInst(packInst(6'b000000, 5'd3, 5'd1, {5'd2, 11'd0}));
    sendInst(packInst(6'b100000, 5'd4, 5'd3, {5'd1, 11'd0}));    // or
    sendInst(packInst(6'b101010, 5'd5, 5'd4, 16'ha5a5));         // xor, negative imm
    sendInst(packInst(6'b100011, 5'd6, 5'd5, {5'd2, 11'd0}));    // and-not
    sendInst(packInst(6'b100100, 5'd1, 5'd6, 16'h0000));

    // Store, load of the same word, loaded value used at once
    sendInst(packInst(6'b111110, 5'd3, 5'd4, 16'h0008));
    sendInst(packInst(6'b111010, 5'd5, 5'd4, 16'h0008));
    sendInst(packInst(6'b000000, 5'd6, 5'd5, {5'd1, 11'd0}));

    // Barrel left by immediate 13, then right by r1
    sendInst(packInst(6'b011001, 5'd2, 5'd6, {5'd0, 11'h40d}));
    sendInst(packInst(6'b010001, 5'd7, 5'd2, {5'd1, 11'h000}));
    sendInst(packInst(6'b000000, 5'd3, 5'd7, {5'd2, 11'd0}));

    // Silent ones, then r0 read back
    sendInst(packInst(6'b001000, 5'd0, 5'd3, 16'h0055));
    sendInst(packInst(6'b000001, 5'd5, 5'd1, 16'h0000));
    sendInst(packInst(6'b000000, 5'd4, 5'd0, {5'd0, 11'd0}));

    // Whole RAM filled, word i holds {i ^ a5, i} sign-extended
    for (int i = 0; i < memDepth; i++) begin
      sendInst(packInst(6'b001000, 5'd1, 5'd0, {8'(i) ^ 8'ha5, 8'(i)}));
      sendInst(packInst(6'b111110, 5'd1, 5'd0, 16'(i * 4)));
    end

    for (int n = 0; n < 400; n++) begin
      sendInst(randomInst());
      if ($urandom_range(0, 3) == 0)
        idleCycles($urandom_range(1, 3));
    end
    instValid <= 1'b0;
    done      <= 1'b1;
  end

endmodule

`default_nettype wire

/* verif/tbCore.sv */
`timescale 1ns/1ps
`default_nettype none

module tbCore;
  import cpuPkg::*;

  localparam int maxCycles   = 4000;  // Preload 512, random stream with gaps near 700
  localparam int drainCycles = 6;     // Barrel reaches wb four edges after acceptance

  logic gclk;
  logic arstN;
  logic instValid;
  instT inst;
  logic instReady;
  wbT   wb;
  logic progDone;
  logic barrelIn;
  logic expAvail;
  wbT   expHead;
  wbT   expQ [$];
  logic [dataWidth-1:0] modelRegs [2**regAddrWidth];
  logic [dataWidth-1:0] modelMem [memDepth];

  cpuCore u_cpuCore (
    .gclk      (gclk),
    .arstN     (arstN),
    .instValid (instValid),
    .inst      (inst),
    .instReady (instReady),
    .wb        (wb)
  );

  tbProgram u_tbProgram (
    .gclk      (gclk),
    .arstN     (arstN),
    .instReady (instReady),
    .instValid (instValid),
    .inst      (inst),
    .done      (progDone)
  );

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic reportWb(input wbT got, input wbT exp, input logic avail);
    if (!avail) begin
      abortRun($sformatf("writeback to r%0d with no instruction expecting it", got.rd));
    end else begin
      if (got.rd != exp.rd)
        $display("ERR wb.rd got %h expected %h", got.rd, exp.rd);
      if (got.data != exp.data)
        $display("ERR wb.data got %h expected %h", got.data, exp.data);
      abortRun("writeback differs from the golden model");
    end
  endtask

  // Golden model, one call per accepted instruction in program order
  task automatic applyToModel(input instT i);
    logic [dataWidth-1:0] a;
    logic [dataWidth-1:0] b;
    logic [dataWidth-1:0] imm;
    logic [dataWidth-1:0] res;
    logic                 writes;
    imm    = {{(dataWidth - 16){i.rb[4]}}, i.rb, i.alt};
    a      = modelRegs[i.ra];
    b      = i.opc[3] ? imm : modelRegs[i.rb];
    res    = a + b;   // Add result and load address
    writes = 1'b1;
    if ((i.opc[5:4] == 2'b10) && !i.opc[2]) begin
      case (i.opc[1:0])
        2'b00:   res = a | b;
        2'b01:   res = a & b;
        2'b10:   res = a ^ b;
        default: res = a & ~b;
      endcase
    end else if (i.opc == 6'b100100) begin
      res = a >> 1;
    end else if ({i.opc[5:4], i.opc[2:0]} == 5'b01001) begin
      res = i.alt[10] ? (a << b[4:0]) : (a >> b[4:0]);
    end else if ((i.opc[5:4] == 2'b11) && (i.opc[2:0] == 3'b010)) begin
      res = modelMem[res[memAddrWidth+1:2]];
    end else if ((i.opc[5:4] == 2'b11) && (i.opc[2:0] == 3'b110)) begin
      res = a + imm;   // Stores always use the immediate offset
      modelMem[res[memAddrWidth+1:2]] = modelRegs[i.rd];
      writes = 1'b0;
    end else if ({i.opc[5:4], i.opc[2:0]} != 5'b00000) begin
      writes = 1'b0;
    end
    if (writes && (i.rd != '0)) begin
      modelRegs[i.rd] = res;
      expQ.push_back(wbT'{valid: 1'b1, rd: i.rd, data: res});
    end
  endtask

  initial begin
    gclk = 1'b0;
    forever #5 gclk = ~gclk;
  end

  initial begin
    arstN    = 1'b0;
    expAvail = 1'b0;
    expHead  = '0;
    for (int i = 0; i < 2**regAddrWidth; i++)
      modelRegs[i] = '0;
    repeat (10) @(posedge gclk);
    arstN <= 1'b1;
    wait (progDone);
    repeat (drainCycles) @(posedge gclk);
    if (expQ.size() == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      abortRun($sformatf("%0d expected writebacks never arrived", expQ.size()));
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < maxCycles) begin
      @(posedge gclk);
      cycles++;
    end
    abortRun($sformatf("run did not finish within %0d cycles", maxCycles));
  end

  // Pre-edge values, as the DUT sees them
  always @(posedge gclk) begin
    if (arstN) begin
      if (wb.valid && (expQ.size() > 0))
        void'(expQ.pop_front());
      if (instValid && instReady)
        applyToModel(inst);
      expAvail = (expQ.size() > 0);
      if (expAvail)
        expHead = expQ[0];
    end
  end

  assign barrelIn = instValid && instReady && ({inst.opc[5:4], inst.opc[2:0]} == 5'b01001);

  // Mid-cycle, so the first reset edge has settled the flops
  aResetState: assert property (@(negedge gclk) !arstN |-> (instReady && !wb.valid))
    else abortRun("instReady low or writeback valid during reset");

  aBarrelStall: assert property (@(posedge gclk) disable iff (!arstN)
    barrelIn |=> !instReady)
    else abortRun("instReady stayed high after a barrel shift was accepted");

  aOneStall: assert property (@(posedge gclk) disable iff (!arstN)
    !instReady |=> instReady)
    else abortRun("instReady was low for more than one cycle");

  aNoStall: assert property (@(posedge gclk) disable iff (!arstN)
    (instReady && !barrelIn) |=> instReady)
    else abortRun("instReady dropped with no barrel shift accepted before it");

  aWbOrder: assert property (@(posedge gclk) disable iff (!arstN)
    wb.valid |-> (expAvail && (wb.rd == expHead.rd) && (wb.data == expHead.data)))
    else reportWb($sampled(wb), $sampled(expHead), $sampled(expAvail));

endmodule

`default_nettype wire

/* verilog.f */
logic/cpuPkg.sv
logic/pipeCtrl.sv
logic/regFile.sv
logic/execUnit.sv
logic/dataMem.sv
logic/cpuCore.sv
verif/tbProgram.sv
verif/tbCore.sv
